// File: filelist.f
ForwardPkg.sv
BypassIf.sv
StallTimer.sv
PipeControl.sv
BypassNetwork.sv
RegisterFile.sv
OperandStage.sv
OperandStage_sva.sv
OperandStageTb.sv

// File: Bender.yml
package:
  name: operand_stage

sources:
  - ForwardPkg.sv
  - BypassIf.sv
  - StallTimer.sv
  - PipeControl.sv
  - BypassNetwork.sv
  - RegisterFile.sv
  - OperandStage.sv
  - target: test
    files:
      - OperandStage_sva.sv
      - OperandStageTb.sv

// File: OperandStageTb.sv
// Self-checking testbench for the operand stage; stops at the first failed check
`timescale 1ns/1ns
`default_nettype none

module OperandStageTb;

    localparam int BusyTimeout = 40;
    localparam int RandomCycles = 3000;

    logic clk = 1'b0;
    logic rstN;
    logic writeEnable;
    ForwardPkg::RegAddrT writeAddr;
    ForwardPkg::WordT writeValue;
    ForwardPkg::RegAddrT readAddr1;
    ForwardPkg::RegAddrT readAddr2;
    logic flushReq;
    logic stallReq;
    ForwardPkg::StallLenT stallLen;
    ForwardPkg::WordT readValue1;
    ForwardPkg::WordT readValue2;
    logic hit1;
    logic hit2;
    logic busy;

    // Reference model, stage 0 is the newest result
    ForwardPkg::WordT shadowRegs [32];
    bit stageValid [ForwardPkg::BypassDepth];
    ForwardPkg::RegAddrT stageAddr [ForwardPkg::BypassDepth];
    ForwardPkg::WordT stageValue [ForwardPkg::BypassDepth];
    bit modelFlush;
    int modelStallLeft;
    logic [31:0] lcgState = 32'd11818;

    OperandStage UUT (.*);

    always #5 clk = ~clk;

    // Upper half of the LCG state, the low bits repeat too quickly
    function automatic logic [15:0] randBits16();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:16];
    endfunction

    function automatic ForwardPkg::WordT randWord();
        return {randBits16(), randBits16()};
    endfunction

    // Mostly a few low registers so results meet in the pipeline, x0 rarely
    function automatic ForwardPkg::RegAddrT pickAddr();
        logic [15:0] r;
        r = randBits16();
        if (r[3:0] == 4'd0) begin
            return '0;
        end else if (r[5:4] == 2'd0) begin
            return ForwardPkg::RegAddrT'(1 + r[15:8] % 31);
        end
        return ForwardPkg::RegAddrT'(1 + r[15:8] % 7);
    endfunction

    function automatic ForwardPkg::WordT refValue(input ForwardPkg::RegAddrT addr);
        ForwardPkg::WordT result;
        result = shadowRegs[addr];
        for (int i = ForwardPkg::BypassDepth - 1; i >= 0; i--) begin
            if (stageValid[i] && stageAddr[i] == addr) begin
                result = stageValue[i];
            end
        end
        return (addr == '0) ? '0 : result;
    endfunction

    function automatic bit refHit(input ForwardPkg::RegAddrT addr);
        bit found;
        found = 1'b0;
        for (int i = 0; i < ForwardPkg::BypassDepth; i++) begin
            found |= stageValid[i] && (stageAddr[i] == addr);
        end
        return found;
    endfunction

    task automatic checkWord(
        input string name,
        input logic [31:0] got,
        input logic [31:0] expected
    );
        assert (got === expected) else begin
            $display("[FAIL] time %0t %s: got %h, expected %h", $time, name, got, expected);
            $display("Done: errors found");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic holdIdle();
        writeEnable <= 1'b0;
        flushReq <= 1'b0;
        stallReq <= 1'b0;
    endtask

    task automatic presentWrite(input ForwardPkg::RegAddrT addr, input ForwardPkg::WordT value);
        writeEnable <= 1'b1;
        writeAddr <= addr;
        writeValue <= value;
    endtask

    // Returns at a falling edge of the first cycle back in Run
    task automatic waitNotBusy();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            if (cycles >= BusyTimeout) begin
                $display("busy never dropped within %0d cycles at %0t", BusyTimeout, $time);
                $display("Done: errors found");
                $fatal(1, "busy timeout");
            end
            @(posedge clk);
            holdIdle();
            @(negedge clk);
            cycles++;
        end
    endtask

    // The write still present in the flush cycle must be discarded
    task automatic issueFlush();
        flushReq <= 1'b1;
        @(posedge clk);
        flushReq <= 1'b0;
        waitNotBusy();
    endtask

    task automatic startStall(input ForwardPkg::StallLenT len);
        stallReq <= 1'b1;
        stallLen <= len;
        @(posedge clk);
        holdIdle();
        waitNotBusy();
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                shadowRegs[i] = '0;
            end
            for (int i = 0; i < ForwardPkg::BypassDepth; i++) begin
                stageValid[i] = 1'b0;
            end
            modelFlush = 1'b0;
            modelStallLeft = 0;
        end else begin
            if (modelFlush) begin
                for (int i = 0; i < ForwardPkg::BypassDepth; i++) begin
                    stageValid[i] = 1'b0;
                end
            end else if (modelStallLeft == 0) begin
                // Oldest result lands in the register file at the same edge
                if (stageValid[ForwardPkg::BypassDepth-1]
                        && stageAddr[ForwardPkg::BypassDepth-1] != '0) begin
                    shadowRegs[stageAddr[ForwardPkg::BypassDepth-1]] =
                        stageValue[ForwardPkg::BypassDepth-1];
                end
                for (int i = ForwardPkg::BypassDepth - 1; i > 0; i--) begin
                    stageValid[i] = stageValid[i-1];
                    stageAddr[i] = stageAddr[i-1];
                    stageValue[i] = stageValue[i-1];
                end
                stageValid[0] = writeEnable;
                stageAddr[0] = writeAddr;
                stageValue[0] = writeValue;
            end
            if (modelFlush) begin
                modelFlush = 1'b0;
            end else if (modelStallLeft != 0) begin
                modelStallLeft--;
            end else if (flushReq) begin
                modelFlush = 1'b1;
            end else if (stallReq) begin
                modelStallLeft = (stallLen == '0) ? 1 : int'(stallLen);
            end
        end
    end

    always @(negedge clk) begin
        assert (UUT.sva.failCount == 0) else begin
            $display("A bound assertion on the pipeline controls failed by %0t", $time);
            $display("Done: errors found");
            $fatal(1, "bound assertion failure");
        end
        if (rstN) begin
            checkWord("readValue1", readValue1, refValue(readAddr1));
            checkWord("readValue2", readValue2, refValue(readAddr2));
            checkWord("hit1", 32'(hit1), 32'(refHit(readAddr1)));
            checkWord("hit2", 32'(hit2), 32'(refHit(readAddr2)));
            checkWord("busy", 32'(busy), 32'(modelFlush || modelStallLeft != 0));
        end
    end

    initial begin
        logic [15:0] r;
        rstN = 1'b0;
        writeEnable = 1'b0;
        writeAddr = '0;
        writeValue = '0;
        readAddr1 = '0;
        readAddr2 = '0;
        flushReq = 1'b0;
        stallReq = 1'b0;
        stallLen = '0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        // Empty pipeline and cleared registers
        repeat (4) begin
            @(posedge clk);
            readAddr1 <= pickAddr();
            readAddr2 <= pickAddr();
        end
        // Forwarding window, then the register file, newest value wins
        readAddr1 <= 5'd5;
        readAddr2 <= 5'd5;
        presentWrite(5'd5, 32'h1111_0005);
        @(posedge clk);
        presentWrite(5'd5, 32'h2222_0005);
        @(posedge clk);
        holdIdle();
        repeat (ForwardPkg::BypassDepth + 2) @(posedge clk);
        // x0 stays zero on both ports
        readAddr1 <= '0;
        readAddr2 <= '0;
        presentWrite('0, 32'hdead_beef);
        @(posedge clk);
        holdIdle();
        repeat (ForwardPkg::BypassDepth + 2) @(posedge clk);
        // Stall freezes a result in flight, zero length acts as one
        readAddr1 <= 5'd6;
        readAddr2 <= 5'd5;
        presentWrite(5'd6, 32'h3333_0006);
        @(posedge clk);
        startStall(4'd4);
        @(posedge clk);
        startStall(4'd0);
        // Flush keeps retired results only
        @(posedge clk);
        readAddr1 <= 5'd7;
        presentWrite(5'd7, 32'h4444_0000);
        for (int i = 1; i <= ForwardPkg::BypassDepth; i++) begin
            @(posedge clk);
            presentWrite(5'd7, 32'h4444_0000 + i);
        end
        @(posedge clk);
        issueFlush();
        repeat (4) @(posedge clk);
        for (int n = 0; n < RandomCycles; n++) begin
            @(posedge clk);
            r = randBits16();
            readAddr1 <= pickAddr();
            readAddr2 <= pickAddr();
            writeEnable <= (r[1:0] != 2'b00);
            writeAddr <= pickAddr();
            writeValue <= randWord();
            if (r[9:5] == 5'd0) begin
                issueFlush();
            end else if (r[9:5] == 5'd1) begin
                startStall(ForwardPkg::StallLenT'(1 + randBits16() % 15));
            end
        end
        @(posedge clk);
        holdIdle();
        repeat (ForwardPkg::BypassDepth + 2) @(posedge clk);
        @(negedge clk);
        if (UUT.sva.failCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("A bound assertion on the pipeline controls failed");
            $display("Done: errors found");
            $fatal(1, "bound assertion failure");
        end
    end

endmodule

`default_nettype wire

// File: OperandStage_sva.sv
// Bound checks on the pipeline controls; the reset is synchronous and active low
`timescale 1ns/1ns
`default_nettype none

module OperandStageSva (
    input wire logic clk,
    input wire logic rstN,
    input wire logic flushReq,
    input wire logic flush,
    input wire logic bypassStall,
    input wire logic retireEnable,
    input wire logic busy
);

    // Number of failed assertions so far
    int unsigned failCount = 0;

    // Flush outranks stall and follows its request by one cycle
    flushOutranksStall: assert property (
        @(posedge clk) disable iff (!rstN) flushReq && !busy |=> flush && !bypassStall
    ) else begin
        $error("flushReq in Run did not give flush alone in the next cycle");
        failCount++;
    end

    flushSingleCycle: assert property (
        @(posedge clk) disable iff (!rstN) flush |=> !flush
    ) else begin
        $error("flush held longer than one cycle");
        failCount++;
    end

    // A frozen pipeline must not retire
    noRetireInStall: assert property (
        @(posedge clk) disable iff (!rstN) bypassStall |-> !retireEnable
    ) else begin
        $error("retirement while bypassStall is high");
        failCount++;
    end

    busyLowAfterReset: assert property (
        @(posedge clk) !rstN |=> !busy
    ) else begin
        $error("busy high after reset");
        failCount++;
    end

endmodule

bind OperandStage OperandStageSva sva (
    .clk(clk),
    .rstN(rstN),
    .flushReq(flushReq),
    .flush(flush),
    .bypassStall(bypassStall),
    .retireEnable(bus.retireEnable),
    .busy(busy)
);

`default_nettype wire

// File: OperandStage.sv
// Operand read stage top; the caller must hold requests and writes while busy is high
`timescale 1ns/1ns
`default_nettype none

module OperandStage (
    input wire logic clk,
    input wire logic rstN,
    input wire logic writeEnable,
    input wire ForwardPkg::RegAddrT writeAddr,
    input wire ForwardPkg::WordT writeValue,
    input wire ForwardPkg::RegAddrT readAddr1,
    input wire ForwardPkg::RegAddrT readAddr2,
    input wire logic flushReq,
    input wire logic stallReq,
    input wire ForwardPkg::StallLenT stallLen,
    output ForwardPkg::WordT readValue1,
    output ForwardPkg::WordT readValue2,
    output logic hit1,
    output logic hit2,
    output logic busy
);

    BypassIf bus ();

    // Controller to bypass network and timer
    logic flush;
    logic bypassStall;
    logic stallLoad;
    logic stallLast;
    ForwardPkg::StallLenT timerLen;

    // Stage side of the bus
    assign bus.writeEnable = writeEnable;
    assign bus.writeAddr = writeAddr;
    assign bus.writeValue = writeValue;
    assign bus.readAddr1 = readAddr1;
    assign bus.readAddr2 = readAddr2;
    assign readValue1 = bus.readValue1;
    assign readValue2 = bus.readValue2;
    assign hit1 = bus.hit1;
    assign hit2 = bus.hit2;

    PipeControl control (
        .clk(clk),
        .rstN(rstN),
        .flushReq(flushReq),
        .stallReq(stallReq),
        .stallLen(stallLen),
        .stallLast(stallLast),
        .flush(flush),
        .bypassStall(bypassStall),
        .stallLoad(stallLoad),
        .stallLenOut(timerLen),
        .busy(busy)
    );

    StallTimer timer (
        .clk(clk),
        .rstN(rstN),
        .stallLoad(stallLoad),
        .stallLen(timerLen),
        .stallLast(stallLast)
    );

    BypassNetwork network (
        .clk(clk),
        .rstN(rstN),
        .flush(flush),
        .bypassStall(bypassStall),
        .bus(bus.network)
    );

    RegisterFile regFile (
        .clk(clk),
        .rstN(rstN),
        .bus(bus.regFile)
    );

endmodule

`default_nettype wire

// File: RegisterFile.sv
// Integer register file with two combinational reads and one write port; x0 is hardwired to zero
`timescale 1ns/1ns
`default_nettype none

module RegisterFile (
    input wire logic clk,
    input wire logic rstN,
    BypassIf.regFile bus
);

    // x0 has no storage
    ForwardPkg::WordT regs [1:2**$bits(ForwardPkg::RegAddrT)-1];

    // Written by the retiring bypass stage
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i <= $high(regs); i++) begin
                regs[i] <= '0;
            end
        end else if (bus.retireEnable && (bus.retireAddr != '0)) begin
            regs[bus.retireAddr] <= bus.retireValue;
        end
    end

    // Read ports
    assign bus.rfValue1 = (bus.readAddr1 == '0) ? '0 : regs[bus.readAddr1];
    assign bus.rfValue2 = (bus.readAddr2 == '0) ? '0 : regs[bus.readAddr2];

endmodule

`default_nettype wire

// File: BypassNetwork.sv
// Forwarding pipeline of BypassDepth stages; a stall holds every stage and drops the incoming write
`timescale 1ns/1ns
`default_nettype none

module BypassNetwork (
    input wire logic clk,
    input wire logic rstN,
    input wire logic flush,
    input wire logic bypassStall,
    BypassIf.network bus
);

    // Stage storage, index 0 is the newest
    logic [ForwardPkg::BypassDepth-1:0] entryValid;
    ForwardPkg::RegAddrT entryAddr [ForwardPkg::BypassDepth];
    ForwardPkg::WordT entryValue [ForwardPkg::BypassDepth];

    // Per-port address match
    logic [ForwardPkg::BypassDepth-1:0] match1;
    logic [ForwardPkg::BypassDepth-1:0] match2;
    ForwardPkg::BypassIndexT index1;
    ForwardPkg::BypassIndexT index2;

    // Lowest matching stage holds the newest result
    function automatic ForwardPkg::BypassIndexT firstMatch(
        input logic [ForwardPkg::BypassDepth-1:0] hits
    );
        ForwardPkg::BypassIndexT index;
        index = '0;
        for (int i = ForwardPkg::BypassDepth - 1; i >= 0; i--) begin
            if (hits[i]) begin
                index = ForwardPkg::BypassIndexT'(i);
            end
        end
        return index;
    endfunction

    function automatic ForwardPkg::WordT selectOperand(
        input ForwardPkg::RegAddrT addr,
        input logic [ForwardPkg::BypassDepth-1:0] hits,
        input ForwardPkg::WordT stageValue,
        input ForwardPkg::WordT rfValue
    );
        ForwardPkg::WordT result;
        if (addr == '0) begin
            result = '0;
        end else if (|hits) begin
            result = stageValue;
        end else begin
            result = rfValue;
        end
        return result;
    endfunction

    always_comb begin
        for (int i = 0; i < ForwardPkg::BypassDepth; i++) begin
            match1[i] = entryValid[i] && (entryAddr[i] == bus.readAddr1);
            match2[i] = entryValid[i] && (entryAddr[i] == bus.readAddr2);
        end
    end

    assign index1 = firstMatch(match1);
    assign index2 = firstMatch(match2);

    // x0 may still report a hit, the value is forced to zero
    assign bus.hit1 = |match1;
    assign bus.hit2 = |match2;
    assign bus.readValue1 = selectOperand(bus.readAddr1, match1, entryValue[index1], bus.rfValue1);
    assign bus.readValue2 = selectOperand(bus.readAddr2, match2, entryValue[index2], bus.rfValue2);

    // Last stage retires only on an edge where it actually shifts out
    assign bus.retireEnable = entryValid[ForwardPkg::BypassDepth-1] && !bypassStall && !flush;
    assign bus.retireAddr = entryAddr[ForwardPkg::BypassDepth-1];
    assign bus.retireValue = entryValue[ForwardPkg::BypassDepth-1];

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            entryValid <= '0;
        end else if (!bypassStall) begin
            entryValid <= {entryValid[ForwardPkg::BypassDepth-2:0], bus.writeEnable};
        end
    end

    // Payload follows the valid bits
    always_ff @(posedge clk) begin
        if (!bypassStall) begin
            entryAddr[0] <= bus.writeAddr;
            entryValue[0] <= bus.writeValue;
            for (int i = 1; i < ForwardPkg::BypassDepth; i++) begin
                entryAddr[i] <= entryAddr[i-1];
                entryValue[i] <= entryValue[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: PipeControl.sv
// Pipeline controller; requests are only taken in Run and flush wins over stall in the same cycle
`timescale 1ns/1ns
`default_nettype none

module PipeControl (
    input wire logic clk,
    input wire logic rstN,
    input wire logic flushReq,
    input wire logic stallReq,
    input wire ForwardPkg::StallLenT stallLen,
    input wire logic stallLast,
    output logic flush,
    output logic bypassStall,
    output logic stallLoad,
    output ForwardPkg::StallLenT stallLenOut,
    output logic busy
);

    ForwardPkg::CtrlStateT state;
    ForwardPkg::CtrlStateT nextState;

    always_comb begin
        nextState = state;
        case (state)
            ForwardPkg::Run: begin
                if (flushReq) begin
                    nextState = ForwardPkg::Flush;
                end else if (stallReq) begin
                    nextState = ForwardPkg::Stall;
                end
            end
            ForwardPkg::Stall: begin
                // Timer flags the final stall cycle
                if (stallLast) begin
                    nextState = ForwardPkg::Run;
                end
            end
            ForwardPkg::Flush: begin
                nextState = ForwardPkg::Run;
            end
            default: begin
                nextState = ForwardPkg::Run;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= ForwardPkg::Run;
        end else begin
            state <= nextState;
        end
    end

    // Controls come straight from the state register
    assign flush = (state == ForwardPkg::Flush);
    assign bypassStall = (state == ForwardPkg::Stall);
    assign busy = (state != ForwardPkg::Run);

    // Timer is loaded on the Run to Stall transition
    assign stallLoad = (state == ForwardPkg::Run) && stallReq && !flushReq;
    assign stallLenOut = stallLen;

endmodule

`default_nettype wire

// File: StallTimer.sv
// Stall timer; a load of zero counts as one cycle, a new load restarts the count
`timescale 1ns/1ns
`default_nettype none

module StallTimer (
    input wire logic clk,
    input wire logic rstN,
    input wire logic stallLoad,
    input wire ForwardPkg::StallLenT stallLen,
    output logic stallLast
);

    // Remaining stall cycles including the current one
    ForwardPkg::StallLenT count;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (stallLoad) begin
            count <= (stallLen == '0) ? ForwardPkg::StallLenT'(1) : stallLen;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign stallLast = (count == ForwardPkg::StallLenT'(1));

endmodule

`default_nettype wire

// File: BypassIf.sv
// Bypass network to register file signals; reads are combinational and writes have no handshake
`timescale 1ns/1ns
`default_nettype none

interface BypassIf;

    // New result from the execute side
    logic writeEnable;
    ForwardPkg::RegAddrT writeAddr;
    ForwardPkg::WordT writeValue;

    // Operand read ports
    ForwardPkg::RegAddrT readAddr1;
    ForwardPkg::RegAddrT readAddr2;
    ForwardPkg::WordT rfValue1;
    ForwardPkg::WordT rfValue2;
    ForwardPkg::WordT readValue1;
    ForwardPkg::WordT readValue2;
    logic hit1;
    logic hit2;

    // Oldest stage leaving the pipeline
    logic retireEnable;
    ForwardPkg::RegAddrT retireAddr;
    ForwardPkg::WordT retireValue;

    modport network (
        input writeEnable, writeAddr, writeValue,
        input readAddr1, readAddr2, rfValue1, rfValue2,
        output readValue1, readValue2, hit1, hit2,
        output retireEnable, retireAddr, retireValue
    );

    modport regFile (
        input readAddr1, readAddr2,
        input retireEnable, retireAddr, retireValue,
        output rfValue1, rfValue2
    );

    modport stage (
        output writeEnable, writeAddr, writeValue,
        output readAddr1, readAddr2,
        input readValue1, readValue2, hit1, hit2
    );

endinterface

`default_nettype wire

// File: ForwardPkg.sv
// Shared widths and types for the RV32 operand stage; integer registers only, depth is fixed
`default_nettype none

package ForwardPkg;

    // Data path widths
    typedef logic [31:0] WordT;
    typedef logic [4:0] RegAddrT;

    // Forwarding pipeline depth, one result per stage
    localparam int unsigned BypassDepth = 3;

    typedef logic [$clog2(BypassDepth)-1:0] BypassIndexT;

    // Stall length in cycles, zero behaves like one
    typedef logic [3:0] StallLenT;

    // Controller states
    typedef enum logic [1:0] {
        Run,
        Stall,
        Flush
    } CtrlStateT;

endpackage

`default_nettype wire
